// ==== rtl/mc_pkg.sv ====
package mc_pkg;

	localparam int read_entries  = 4;
	localparam int write_entries = 4;
	localparam int total_entries = read_entries + write_entries;
	localparam int addr_width    = 8;
	localparam int data_width    = 32;
	localparam int tag_width     = 4;
	localparam int mem_latency   = 2;   // command to completion, cycles

	typedef logic [addr_width-1:0]           addr_t;
	typedef logic [data_width-1:0]           data_t;
	typedef logic [tag_width-1:0]            tag_t;
	typedef logic [$clog2(read_entries)-1:0] slot_t;   // both pools share this width
	typedef logic                            req_kind_t;
	typedef logic [total_entries-1:0]        dep_mask_t; // reads low, writes high

	localparam req_kind_t kind_read  = 1'b0;
	localparam req_kind_t kind_write = 1'b1;

	typedef struct packed {
		req_kind_t kind;
		addr_t     addr;
		data_t     data;
		tag_t      tag;
	} host_req_t;

	typedef struct packed {
		logic      valid;
		logic      issued;   // sent to the store, waiting for completion
		req_kind_t kind;
		addr_t     addr;
		data_t     data;
		tag_t      tag;
		dep_mask_t dep;
	} array_entry_t;

	typedef struct packed {
		req_kind_t kind;
		slot_t     slot;
		addr_t     addr;
		data_t     data;
		tag_t      tag;
	} mem_cmd_t;

	typedef struct packed {
		req_kind_t kind;
		slot_t     slot;
		data_t     data;
		tag_t      tag;
	} mem_cpl_t;

	typedef struct packed {
		req_kind_t kind;
		data_t     data;
		tag_t      tag;
	} host_rsp_t;

	typedef struct packed {
		req_kind_t kind;
		slot_t     slot;
	} slot_free_t;

endpackage

// ==== rtl/request_mapper.sv ====
`timescale 1ns/1ps

module request_mapper (
	input  logic                                            clk,
	input  logic                                            rst,
	input  logic                                            req_valid,
	input  mc_pkg::host_req_t                               req,
	input  mc_pkg::slot_free_t                              free,
	input  logic                                            free_valid,
	input  mc_pkg::array_entry_t [mc_pkg::read_entries-1:0]  read_view,
	input  mc_pkg::array_entry_t [mc_pkg::write_entries-1:0] write_view,
	output logic                                            ins_valid,
	output mc_pkg::req_kind_t                               ins_kind,
	output mc_pkg::slot_t                                   ins_slot,
	output mc_pkg::array_entry_t                            ins_entry
);
	import mc_pkg::*;

	logic [read_entries-1:0]  rd_free;   // 1 = slot available
	logic [write_entries-1:0] wr_free;
	logic                     rd_found;
	logic                     wr_found;
	slot_t                    rd_slot;
	slot_t                    wr_slot;
	logic [read_entries-1:0]  rd_busy;
	logic [write_entries-1:0] wr_busy;

	// lowest free slot per pool, the loop runs downward so the last hit wins
	always_comb begin
		rd_found = 1'b0;
		rd_slot  = '0;
		for (int i = read_entries - 1; i >= 0; i--) begin
			if (rd_free[i]) begin
				rd_found = 1'b1;
				rd_slot  = slot_t'(i);
			end
		end
		wr_found = 1'b0;
		wr_slot  = '0;
		for (int i = write_entries - 1; i >= 0; i--) begin
			if (wr_free[i]) begin
				wr_found = 1'b1;
				wr_slot  = slot_t'(i);
			end
		end
	end

	always_comb begin
		for (int i = 0; i < read_entries; i++)
			rd_busy[i] = read_view[i].valid;
		for (int i = 0; i < write_entries; i++)
			wr_busy[i] = write_view[i].valid;
	end

	assign ins_kind  = req.kind;
	assign ins_slot  = (req.kind == kind_read) ? rd_slot : wr_slot;
	assign ins_valid = req_valid && ((req.kind == kind_read) ? rd_found : wr_found);

	always_comb begin
		ins_entry        = '0;
		ins_entry.valid  = 1'b1;
		ins_entry.issued = 1'b0;
		ins_entry.kind   = req.kind;
		ins_entry.addr   = req.addr;
		ins_entry.data   = req.data;
		ins_entry.tag    = req.tag;
		if (req.kind == kind_read)
			ins_entry.dep = {wr_busy, {read_entries{1'b0}}};   // writes only
		else
			ins_entry.dep = {wr_busy, rd_busy};               // everything in flight
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_free <= '1;
			wr_free <= '1;
		end else begin
			if (ins_valid && ins_kind == kind_read)
				rd_free[ins_slot] <= 1'b0;
			if (ins_valid && ins_kind == kind_write)
				wr_free[ins_slot] <= 1'b0;
			if (free_valid && free.kind == kind_read)
				rd_free[free.slot] <= 1'b1;
			if (free_valid && free.kind == kind_write)
				wr_free[free.slot] <= 1'b1;
		end
	end

endmodule

// ==== rtl/global_array.sv ====
`timescale 1ns/1ps

module global_array (
	input  logic                                            clk,
	input  logic                                            rst,
	input  logic                                            ins_valid,
	input  mc_pkg::req_kind_t                               ins_kind,
	input  mc_pkg::slot_t                                   ins_slot,
	input  mc_pkg::array_entry_t                            ins_entry,
	input  logic                                            issue_valid,
	input  mc_pkg::req_kind_t                               issue_kind,
	input  mc_pkg::slot_t                                   issue_slot,
	input  logic                                            free_valid,
	input  mc_pkg::slot_free_t                              free,
	output mc_pkg::array_entry_t [mc_pkg::read_entries-1:0]  read_view,
	output mc_pkg::array_entry_t [mc_pkg::write_entries-1:0] write_view
);
	import mc_pkg::*;

	array_entry_t [read_entries-1:0]  rd_arr;
	array_entry_t [write_entries-1:0] wr_arr;
	dep_mask_t                        clr_mask;   // dep bit of the slot being freed
	array_entry_t                     ins_clean;

	always_comb begin
		clr_mask = '0;
		if (free_valid) begin
			if (free.kind == kind_read)
				clr_mask[free.slot] = 1'b1;
			else
				clr_mask[read_entries + free.slot] = 1'b1;
		end
		ins_clean     = ins_entry;
		ins_clean.dep = ins_entry.dep & ~clr_mask;   // freed slot no longer blocks
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < read_entries; i++) begin
				rd_arr[i].valid  <= 1'b0;
				rd_arr[i].issued <= 1'b0;
			end
			for (int i = 0; i < write_entries; i++) begin
				wr_arr[i].valid  <= 1'b0;
				wr_arr[i].issued <= 1'b0;
			end
		end else begin
			for (int i = 0; i < read_entries; i++)
				rd_arr[i].dep <= rd_arr[i].dep & ~clr_mask;
			for (int i = 0; i < write_entries; i++)
				wr_arr[i].dep <= wr_arr[i].dep & ~clr_mask;
			if (free_valid && free.kind == kind_read)
				rd_arr[free.slot].valid <= 1'b0;
			if (free_valid && free.kind == kind_write)
				wr_arr[free.slot].valid <= 1'b0;
			if (issue_valid && issue_kind == kind_read)
				rd_arr[issue_slot].issued <= 1'b1;
			if (issue_valid && issue_kind == kind_write)
				wr_arr[issue_slot].issued <= 1'b1;
			if (ins_valid && ins_kind == kind_read)
				rd_arr[ins_slot] <= ins_clean;   // overrides the dep clear above
			if (ins_valid && ins_kind == kind_write)
				wr_arr[ins_slot] <= ins_clean;
		end
	end

	assign read_view  = rd_arr;
	assign write_view = wr_arr;

endmodule

// ==== rtl/entry_picker.sv ====
`timescale 1ns/1ps

module entry_picker #(
	parameter int pool_entries = 4
) (
	input  mc_pkg::array_entry_t [pool_entries-1:0] view,
	output logic                                    pick_valid,
	output mc_pkg::slot_t                           pick_slot
);
	import mc_pkg::*;

	logic [pool_entries-1:0] ready;   // entries that may go to the store now

	always_comb begin
		for (int i = 0; i < pool_entries; i++)
			ready[i] = view[i].valid && !view[i].issued && (view[i].dep == '0);
	end

	// lowest ready index
	always_comb begin
		pick_valid = 1'b0;
		pick_slot  = '0;
		for (int i = pool_entries - 1; i >= 0; i--) begin
			if (ready[i]) begin
				pick_valid = 1'b1;
				pick_slot  = slot_t'(i);
			end
		end
	end

endmodule

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
	input  logic                                            clk,
	input  logic                                            rst,
	input  logic                                            rd_valid,
	input  mc_pkg::slot_t                                   rd_slot,
	input  logic                                            wr_valid,
	input  mc_pkg::slot_t                                   wr_slot,
	input  mc_pkg::array_entry_t [mc_pkg::read_entries-1:0]  read_view,
	input  mc_pkg::array_entry_t [mc_pkg::write_entries-1:0] write_view,
	output logic                                            cmd_valid,
	output mc_pkg::mem_cmd_t                                cmd,
	output logic                                            issue_valid,
	output mc_pkg::req_kind_t                               issue_kind,
	output mc_pkg::slot_t                                   issue_slot
);
	import mc_pkg::*;

	logic         prio_wr;   // 1 = write picker wins a tie
	logic         gnt_rd;
	array_entry_t sel;

	assign gnt_rd      = rd_valid && (!wr_valid || !prio_wr);
	assign issue_valid = rd_valid || wr_valid;
	assign issue_kind  = gnt_rd ? kind_read : kind_write;
	assign issue_slot  = gnt_rd ? rd_slot : wr_slot;
	assign sel         = gnt_rd ? read_view[rd_slot] : write_view[wr_slot];

	always_ff @(posedge clk) begin
		if (rst) begin
			prio_wr   <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= issue_valid;
			if (rd_valid && wr_valid)
				prio_wr <= !prio_wr;   // alternate only under contention
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			cmd.kind <= issue_kind;
			cmd.slot <= issue_slot;
			cmd.addr <= sel.addr;
			cmd.data <= sel.data;
			cmd.tag  <= sel.tag;
		end
	end

endmodule

// ==== rtl/backing_store.sv ====
`timescale 1ns/1ps

module backing_store (
	input  logic             clk,
	input  logic             rst,
	input  logic             cmd_valid,
	input  mc_pkg::mem_cmd_t cmd,
	output logic             cpl_valid,
	output mc_pkg::mem_cpl_t cpl
);
	import mc_pkg::*;

	data_t                       mem [2**addr_width];
	logic [mem_latency-1:0]      pipe_valid;
	mem_cpl_t [mem_latency-1:0]  pipe;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**addr_width; i++)
				mem[i] <= '0;   // unwritten addresses read as zero
		end else if (cmd_valid && cmd.kind == kind_write) begin
			mem[cmd.addr] <= cmd.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			pipe_valid <= '0;
		else
			pipe_valid <= {pipe_valid[mem_latency-2:0], cmd_valid};
	end

	always_ff @(posedge clk) begin
		pipe[0].kind <= cmd.kind;
		pipe[0].slot <= cmd.slot;
		pipe[0].tag  <= cmd.tag;
		pipe[0].data <= (cmd.kind == kind_read) ? mem[cmd.addr] : cmd.data;
		for (int i = 1; i < mem_latency; i++)
			pipe[i] <= pipe[i-1];
	end

	assign cpl_valid = pipe_valid[mem_latency-1];
	assign cpl       = pipe[mem_latency-1];

endmodule

// ==== rtl/response_returner.sv ====
`timescale 1ns/1ps

module response_returner (
	input  logic               clk,
	input  logic               rst,
	input  logic               cpl_valid,
	input  mc_pkg::mem_cpl_t   cpl,
	output logic               rsp_valid,
	output mc_pkg::host_rsp_t  rsp,
	output logic               free_valid,
	output mc_pkg::slot_free_t free,
	output logic               read_credit,
	output logic               write_credit
);
	import mc_pkg::*;

	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_valid    <= 1'b0;
			free_valid   <= 1'b0;
			read_credit  <= 1'b0;
			write_credit <= 1'b0;
		end else begin
			rsp_valid    <= cpl_valid;
			free_valid   <= cpl_valid;
			read_credit  <= cpl_valid && cpl.kind == kind_read;
			write_credit <= cpl_valid && cpl.kind == kind_write;
		end
	end

	// payload follows the completion, valid bits above qualify it
	always_ff @(posedge clk) begin
		if (cpl_valid) begin
			rsp.kind  <= cpl.kind;
			rsp.tag   <= cpl.tag;
			rsp.data  <= (cpl.kind == kind_write) ? '0 : cpl.data;   // writes answer zero
			free.kind <= cpl.kind;
			free.slot <= cpl.slot;
		end
	end

endmodule

// ==== rtl/mc_request_buffer.sv ====
`timescale 1ns/1ps

module mc_request_buffer (
	input  logic              clk,
	input  logic              rst,
	input  logic              req_valid,
	input  mc_pkg::host_req_t req,
	output logic              rsp_valid,
	output mc_pkg::host_rsp_t rsp,
	output logic              read_credit,
	output logic              write_credit
);
	import mc_pkg::*;

	logic                             ins_valid;
	req_kind_t                        ins_kind;
	slot_t                            ins_slot;
	array_entry_t                     ins_entry;
	array_entry_t [read_entries-1:0]  read_view;
	array_entry_t [write_entries-1:0] write_view;
	logic                             rd_valid;
	slot_t                            rd_slot;
	logic                             wr_valid;
	slot_t                            wr_slot;
	logic                             issue_valid;
	req_kind_t                        issue_kind;
	slot_t                            issue_slot;
	logic                             cmd_valid;
	mem_cmd_t                         cmd;
	logic                             cpl_valid;
	mem_cpl_t                         cpl;
	logic                             free_valid;
	slot_free_t                       free;

	request_mapper u_mapper (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req        (req),
		.free       (free),
		.free_valid (free_valid),
		.read_view  (read_view),
		.write_view (write_view),
		.ins_valid  (ins_valid),
		.ins_kind   (ins_kind),
		.ins_slot   (ins_slot),
		.ins_entry  (ins_entry)
	);

	global_array u_array (
		.clk         (clk),
		.rst         (rst),
		.ins_valid   (ins_valid),
		.ins_kind    (ins_kind),
		.ins_slot    (ins_slot),
		.ins_entry   (ins_entry),
		.issue_valid (issue_valid),
		.issue_kind  (issue_kind),
		.issue_slot  (issue_slot),
		.free_valid  (free_valid),
		.free        (free),
		.read_view   (read_view),
		.write_view  (write_view)
	);

	entry_picker #(.pool_entries(read_entries)) u_rd_picker (
		.view       (read_view),
		.pick_valid (rd_valid),
		.pick_slot  (rd_slot)
	);

	entry_picker #(.pool_entries(write_entries)) u_wr_picker (
		.view       (write_view),
		.pick_valid (wr_valid),
		.pick_slot  (wr_slot)
	);

	bus_arbiter u_arbiter (
		.clk         (clk),
		.rst         (rst),
		.rd_valid    (rd_valid),
		.rd_slot     (rd_slot),
		.wr_valid    (wr_valid),
		.wr_slot     (wr_slot),
		.read_view   (read_view),
		.write_view  (write_view),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.issue_valid (issue_valid),
		.issue_kind  (issue_kind),
		.issue_slot  (issue_slot)
	);

	backing_store u_store (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cpl_valid (cpl_valid),
		.cpl       (cpl)
	);

	response_returner u_returner (
		.clk          (clk),
		.rst          (rst),
		.cpl_valid    (cpl_valid),
		.cpl          (cpl),
		.rsp_valid    (rsp_valid),
		.rsp          (rsp),
		.free_valid   (free_valid),
		.free         (free),
		.read_credit  (read_credit),
		.write_credit (write_credit)
	);

endmodule

// ==== sim/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
	input  logic              clk,
	input  logic              rst,
	input  logic              req_valid,
	input  mc_pkg::host_req_t req,
	input  logic              rsp_valid,
	input  mc_pkg::host_rsp_t rsp,
	input  logic              read_credit,
	input  logic              write_credit,
	input  logic              report,
	output int                errors,
	output int                rd_rsp_count,
	output int                wr_rsp_count,
	output int                pending_count
);
	import mc_pkg::*;

	localparam int num_tags = 2**tag_width;

	data_t     model_mem [2**addr_width];   // host view of memory in acceptance order
	logic      exp_pending [num_tags];
	req_kind_t exp_kind [num_tags];
	data_t     exp_data [num_tags];
	int        err_cnt = 0;
	int        rd_rsp = 0;
	int        wr_rsp = 0;
	int        rd_cred = 0;
	int        wr_cred = 0;
	int        pending = 0;

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**addr_width; i++)
				model_mem[i] = '0;
			for (int i = 0; i < num_tags; i++)
				exp_pending[i] = 1'b0;
			rd_rsp  = 0;
			wr_rsp  = 0;
			rd_cred = 0;
			wr_cred = 0;
			pending = 0;
		end else begin
			// responses first so a request in the same cycle may reuse the tag
			if (rsp_valid) begin
				if (!exp_pending[rsp.tag]) begin
					$display("response with unknown tag %0d", rsp.tag);
					err_cnt++;
				end else begin
					if (rsp.kind !== exp_kind[rsp.tag]) begin
						$display("[FAIL] rsp_kind tag %0d: expected %0d, actual %0d",
							rsp.tag, exp_kind[rsp.tag], rsp.kind);
						err_cnt++;
					end
					if (rsp.data !== exp_data[rsp.tag]) begin
						$display("[FAIL] %s tag %0d: expected %h, actual %h",
							(exp_kind[rsp.tag] == kind_read) ? "read_data" : "write_data",
							rsp.tag, exp_data[rsp.tag], rsp.data);
						err_cnt++;
					end
					exp_pending[rsp.tag] = 1'b0;
					pending--;
				end
				if (rsp.kind == kind_read)
					rd_rsp++;
				else
					wr_rsp++;
			end
			if (read_credit !== (rsp_valid && rsp.kind == kind_read)) begin
				$display("read credit pulse does not line up with a read response");
				err_cnt++;
			end
			if (write_credit !== (rsp_valid && rsp.kind == kind_write)) begin
				$display("write credit pulse does not line up with a write response");
				err_cnt++;
			end
			if (read_credit)
				rd_cred++;
			if (write_credit)
				wr_cred++;
			if (req_valid) begin
				if (exp_pending[req.tag]) begin
					$display("tag %0d reused while still outstanding", req.tag);
					err_cnt++;
				end else begin
					pending++;
				end
				exp_pending[req.tag] = 1'b1;
				exp_kind[req.tag]    = req.kind;
				if (req.kind == kind_write) begin
					model_mem[req.addr] = req.data;
					exp_data[req.tag]   = '0;   // writes answer zero
				end else begin
					exp_data[req.tag] = model_mem[req.addr];
				end
			end
			if (report) begin
				for (int i = 0; i < num_tags; i++) begin
					if (exp_pending[i]) begin
						$display("request with tag %0d never completed", i);
						err_cnt++;
					end
				end
				if (rd_cred != rd_rsp || wr_cred != wr_rsp) begin
					$display("credit totals differ from response totals");
					err_cnt++;
				end
			end
		end
	end

	assign errors        = err_cnt;
	assign rd_rsp_count  = rd_rsp;
	assign wr_rsp_count  = wr_rsp;
	assign pending_count = pending;

endmodule

// ==== sim/tb_mc_request_buffer.sv ====
`timescale 1ns/1ps

module tb_mc_request_buffer;
	import mc_pkg::*;

	localparam int num_ops        = 24;
	localparam int timeout_cycles = num_ops * (mem_latency + total_entries + 8) + 50;

	logic      clk = 1'b0;
	logic      rst = 1'b1;
	logic      req_valid = 1'b0;
	host_req_t req = '0;
	logic      rsp_valid;
	host_rsp_t rsp;
	logic      read_credit;
	logic      write_credit;
	logic      report = 1'b0;
	int        errors;
	int        rd_rsp_count;
	int        wr_rsp_count;
	int        pending_count;

	host_req_t   ops [num_ops];
	logic        burst [num_ops];   // 1 = no idle cycles before this op
	logic [31:0] lcg_state = 32'h7aa88aec;
	int          rd_spent = 0;
	int          wr_spent = 0;
	int          rd_returned = 0;
	int          wr_returned = 0;
	int          cycle_count = 0;
	logic        timed_out = 1'b0;
	int          total_errors;
	int          idle;

	mc_request_buffer uut (
		.clk          (clk),
		.rst          (rst),
		.req_valid    (req_valid),
		.req          (req),
		.rsp_valid    (rsp_valid),
		.rsp          (rsp),
		.read_credit  (read_credit),
		.write_credit (write_credit)
	);

	tb_checker u_checker (
		.clk           (clk),
		.rst           (rst),
		.req_valid     (req_valid),
		.req           (req),
		.rsp_valid     (rsp_valid),
		.rsp           (rsp),
		.read_credit   (read_credit),
		.write_credit  (write_credit),
		.report        (report),
		.errors        (errors),
		.rd_rsp_count  (rd_rsp_count),
		.wr_rsp_count  (wr_rsp_count),
		.pending_count (pending_count)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
			timed_out <= 1'b1;
		if (!rst && read_credit)
			rd_returned <= rd_returned + 1;
		if (!rst && write_credit)
			wr_returned <= wr_returned + 1;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic credit_free(input req_kind_t kind);
		if (kind == kind_read)
			return (read_entries + rd_returned - rd_spent) > 0;
		return (write_entries + wr_returned - wr_spent) > 0;
	endfunction

	task automatic put_op(input int idx, input req_kind_t kind, input addr_t addr,
			input data_t data, input tag_t tag, input logic no_gap);
		ops[idx]   = '{kind: kind, addr: addr, data: data, tag: tag};
		burst[idx] = no_gap;
	endtask

	// drives one request for a single cycle
	task automatic send_op(input host_req_t op);
		while (!credit_free(op.kind) && !timed_out)
			@(negedge clk);
		if (!timed_out) begin
			req       = op;
			req_valid = 1'b1;
			if (op.kind == kind_read)
				rd_spent++;
			else
				wr_spent++;
			@(negedge clk);
			req_valid = 1'b0;
		end
	endtask

	initial begin
		put_op(0,  kind_read,  8'h10, 32'h0,        4'd0,  1'b0);   // never written
		put_op(1,  kind_write, 8'h10, 32'ha1a1a1a1, 4'd1,  1'b0);
		put_op(2,  kind_read,  8'h10, 32'h0,        4'd2,  1'b0);
		put_op(3,  kind_write, 8'h20, 32'h2020beef, 4'd3,  1'b1);   // write then read at once
		put_op(4,  kind_read,  8'h20, 32'h0,        4'd4,  1'b1);
		put_op(5,  kind_write, 8'h20, 32'h20202021, 4'd5,  1'b1);
		put_op(6,  kind_read,  8'h20, 32'h0,        4'd6,  1'b1);
		put_op(7,  kind_write, 8'h30, 32'h30303030, 4'd7,  1'b1);   // fill both pools
		put_op(8,  kind_write, 8'h31, 32'h31313131, 4'd8,  1'b1);
		put_op(9,  kind_write, 8'h32, 32'h32323232, 4'd9,  1'b1);
		put_op(10, kind_write, 8'h33, 32'h33333333, 4'd10, 1'b1);
		put_op(11, kind_read,  8'h30, 32'h0,        4'd11, 1'b1);
		put_op(12, kind_read,  8'h31, 32'h0,        4'd12, 1'b1);
		put_op(13, kind_read,  8'h32, 32'h0,        4'd13, 1'b1);
		put_op(14, kind_read,  8'h33, 32'h0,        4'd14, 1'b1);
		put_op(15, kind_write, 8'h40, 32'h40404040, 4'd15, 1'b0);   // interleaved
		put_op(16, kind_read,  8'h41, 32'h0,        4'd0,  1'b0);
		put_op(17, kind_write, 8'h41, 32'h41414141, 4'd1,  1'b0);
		put_op(18, kind_read,  8'h40, 32'h0,        4'd2,  1'b0);
		put_op(19, kind_write, 8'h40, 32'h4040cafe, 4'd3,  1'b0);
		put_op(20, kind_read,  8'h41, 32'h0,        4'd4,  1'b0);
		put_op(21, kind_read,  8'h40, 32'h0,        4'd5,  1'b0);
		put_op(22, kind_write, 8'h42, 32'h42424242, 4'd6,  1'b0);
		put_op(23, kind_read,  8'h42, 32'h0,        4'd7,  1'b1);

		repeat (5) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		for (int i = 0; i < num_ops; i++) begin
			if (!burst[i]) begin
				lcg_state = lcg_next(lcg_state);
				idle      = int'(lcg_state[17:16]);   // 0 to 3 idle cycles
				repeat (idle) @(negedge clk);
			end
			send_op(ops[i]);
			if (timed_out)
				break;
		end
		while (pending_count != 0 && !timed_out)
			@(negedge clk);

		if (timed_out)
			$display("timeout after %0d cycles with requests still open", cycle_count);
		report = 1'b1;
		@(posedge clk);
		@(negedge clk);
		report = 1'b0;

		total_errors = errors + (timed_out ? 1 : 0);
		$display("errors=%0d read_rsp=%0d write_rsp=%0d", total_errors, rd_rsp_count,
			wr_rsp_count);
		if (total_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== sources.f ====
rtl/mc_pkg.sv
rtl/request_mapper.sv
rtl/global_array.sv
rtl/entry_picker.sv
rtl/bus_arbiter.sv
rtl/backing_store.sv
rtl/response_returner.sv
rtl/mc_request_buffer.sv
sim/tb_checker.sv
sim/tb_mc_request_buffer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the request buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal -f sources.f \
	--top-module tb_mc_request_buffer -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "TEST PASS" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
